//--- all.f
+incdir+verilog
verilog/bpu_pkg.sv
verilog/csr_hash.sv
verilog/pht_bram.sv
verilog/base_predictor.sv
verilog/tagged_predictor.sv
verilog/tage_predictor.sv
verification/tage_predictor_assert.sv
verification/tage_predictor_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the TAGE predictor simulation with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wall -Wno-fatal \
    --top-module tage_predictor_tb -Mdir obj_dir -f all.f
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

./obj_dir/Vtage_predictor_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
fi

if grep -q "^TEST PASSED$" "$LOG"; then
    exit 0
fi
exit 1

//--- verification/tage_predictor_assert.sv
// Predictor interface assertions
`timescale 1ns/100ps
`default_nettype none

module tage_predictor_assert (
    input wire logic                clk,
    input wire logic                rst_i,
    input wire logic                pred_req_i,
    input wire logic                pred_valid_o,
    input wire bpu_pkg::pred_meta_t pred_meta_o
);

    // Result comes exactly one cycle after the request
    valid_follows_req: assert property (@(posedge clk) disable iff (rst_i)
        pred_valid_o == $past(pred_req_i))
        else $error("pred_valid_o does not follow pred_req_i by one cycle");

    // Quiet while in reset
    no_valid_in_reset: assert property (@(posedge clk) rst_i |=> !pred_valid_o)
        else $error("pred_valid_o high during reset");

    // Code 3 is not a provider
    provider_legal: assert property (@(posedge clk) disable iff (rst_i)
        pred_valid_o |-> (pred_meta_o.provider != 2'd3))
        else $error("pred_meta_o provider code is unused value");

endmodule

bind tage_predictor tage_predictor_assert u_assert (
    .clk         (clk),
    .rst_i       (rst_i),
    .pred_req_i  (pred_req_i),
    .pred_valid_o(pred_valid_o),
    .pred_meta_o (pred_meta_o)
);

`default_nettype wire

//--- verification/tage_predictor_tb.sv
// TAGE predictor testbench
`timescale 1ns/100ps
`default_nettype none

`include "bpu_config.svh"

module tage_predictor_tb;

    typedef enum logic [1:0] {
        K_NEVER, K_ALWAYS, K_ALTERNATE, K_RANDOM
    } kind_e;

    typedef struct packed {
        kind_e                      kind;
        logic [`BPU_ADDR_WIDTH-1:0] pc;
        logic [15:0]                count;
    } stim_row_t;

    localparam int NUM_ROWS = 5;
    localparam int TIMEOUT_CYCLES = 20;

    logic                       clk;
    logic                       rst_i;
    logic                       pred_req_i;
    logic [`BPU_ADDR_WIDTH-1:0] pc_i;
    logic                       pred_valid_o;
    logic                       pred_taken_o;
    bpu_pkg::pred_meta_t        pred_meta_o;
    logic                       resolve_valid_i;
    logic [`BPU_ADDR_WIDTH-1:0] resolve_pc_i;
    logic                       resolve_taken_i;
    bpu_pkg::pred_meta_t        resolve_meta_i;

    stim_row_t stim [NUM_ROWS];

    tage_predictor u_dut (
        .clk            (clk),
        .rst_i          (rst_i),
        .pred_req_i     (pred_req_i),
        .pc_i           (pc_i),
        .pred_valid_o   (pred_valid_o),
        .pred_taken_o   (pred_taken_o),
        .pred_meta_o    (pred_meta_o),
        .resolve_valid_i(resolve_valid_i),
        .resolve_pc_i   (resolve_pc_i),
        .resolve_taken_i(resolve_taken_i),
        .resolve_meta_i (resolve_meta_i)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else
            stop_with_failure($sformatf("[FAIL] t=%0t %s got %0h expected %0h",
                                        $time, name, got, exp));
    endtask

    // One request, wait for the result, then resolve with the echoed metadata
    task automatic predict_and_resolve(input logic [`BPU_ADDR_WIDTH-1:0] pc,
                                       input logic taken, output logic pred,
                                       output bpu_pkg::provider_e prov);
        int                  waited;
        bpu_pkg::pred_meta_t meta;
        waited = 0;
        @(posedge clk);
        #2;
        pred_req_i = 1'b1;
        pc_i = pc;
        @(posedge clk);
        #2;
        pred_req_i = 1'b0;
        while (!pred_valid_o) begin
            waited++;
            assert (waited < TIMEOUT_CYCLES) else
                stop_with_failure("No prediction came back before the timeout");
            @(posedge clk);
            #2;
        end
        meta = pred_meta_o;
        pred = pred_taken_o;
        prov = meta.provider;
        check_value("pred_meta_o.taken", 32'(meta.taken), 32'(pred));
        // Base table is indexed by the word address bits
        check_value("pred_meta_o.base_index", 32'(meta.base_index), 32'(pc[9:2]));
        if (meta.provider == bpu_pkg::PROV_BASE) begin
            check_value("pred_meta_o.base_ctr[1]", 32'(meta.base_ctr[1]), 32'(pred));
        end
        resolve_valid_i = 1'b1;
        resolve_pc_i = pc;
        resolve_taken_i = taken;
        resolve_meta_i = meta;
        @(posedge clk);
        #2;
        resolve_valid_i = 1'b0;
    endtask

    task automatic run_row(input stim_row_t row, input bit first_after_reset);
        logic                             pred;
        logic                             outcome;
        logic [`BPU_ADDR_WIDTH-1:0]       pc;
        bpu_pkg::provider_e               prov;
        int                               misses;
        misses = 0;
        for (int i = 0; i < row.count; i++) begin
            pc = row.pc;
            case (row.kind)
                K_NEVER:     outcome = 1'b0;
                K_ALWAYS:    outcome = 1'b1;
                K_ALTERNATE: outcome = (i % 2 == 0);
                default: begin
                    pc = $urandom & 32'h0000_fffc;
                    outcome = $urandom % 2;
                end
            endcase
            predict_and_resolve(pc, outcome, pred, prov);
            if (pred != outcome) begin
                misses++;
            end
            // Zeroed tables give a base not-taken first prediction
            if (first_after_reset && i == 0) begin
                check_value("pred_taken_o", 32'(pred), 32'd0);
                check_value("pred_meta_o.provider", 32'(prov), 32'(bpu_pkg::PROV_BASE));
            end
            if (row.kind == K_NEVER) begin
                check_value("pred_taken_o", 32'(pred), 32'd0);
            end
            if (row.kind == K_ALWAYS && i >= row.count - 10) begin
                check_value("pred_taken_o", 32'(pred), 32'd1);
            end
            if (row.kind == K_ALTERNATE && i >= row.count - 16) begin
                check_value("pred_taken_o", 32'(pred), 32'(outcome));
                assert (prov != bpu_pkg::PROV_BASE) else
                    stop_with_failure("Alternating branch not served by a tagged bank");
            end
        end
        if (row.kind == K_ALWAYS) begin
            assert (misses <= 3) else
                stop_with_failure($sformatf("Always-taken branch mispredicted %0d times",
                                            misses));
        end
    endtask

    initial begin
        rst_i = 1'b1;
        pred_req_i = 1'b0;
        pc_i = '0;
        resolve_valid_i = 1'b0;
        resolve_pc_i = '0;
        resolve_taken_i = 1'b0;
        resolve_meta_i = '0;
        void'($urandom(32'h56ad_8c9c));

        stim[0] = '{K_NEVER,     32'h0000_1040, 16'd8};
        stim[1] = '{K_ALWAYS,    32'h0000_2a8c, 16'd20};
        stim[2] = '{K_ALTERNATE, 32'h0000_3154, 16'd60};
        stim[3] = '{K_RANDOM,    32'h0000_0000, 16'd40};
        stim[4] = '{K_ALWAYS,    32'h0000_47e8, 16'd20};

        repeat (3) @(posedge clk);
        #2;
        rst_i = 1'b0;

        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(stim[r], r == 0);
        end

        repeat (2) @(posedge clk);
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/base_predictor.sv
// Bimodal base predictor
`timescale 1ns/100ps
`default_nettype none

`include "bpu_config.svh"

module base_predictor (
    input  wire logic                                clk,
    input  wire logic                                rst_i,
    input  wire logic [`BPU_ADDR_WIDTH-1:0]          pc_i,
    output logic      [bpu_pkg::BASE_IDX_WIDTH-1:0]  base_index_o,
    output bpu_pkg::base_ctr_t                       ctr_o,
    input  wire logic                                update_valid_i,
    input  wire logic [bpu_pkg::BASE_IDX_WIDTH-1:0]  update_index_i,
    input  wire bpu_pkg::base_ctr_t                  update_ctr_i,
    input  wire logic                                inc_ctr_i
);

    logic [bpu_pkg::BASE_IDX_WIDTH-1:0] query_index;
    bpu_pkg::base_ctr_t                 next_ctr;

    // Word address bits select the counter
    assign query_index = pc_i[2 +: bpu_pkg::BASE_IDX_WIDTH];

    // Index lines up with the registered read
    always_ff @(posedge clk) begin
        if (rst_i) begin
            base_index_o <= '0;
        end else begin
            base_index_o <= query_index;
        end
    end

    // Saturating step
    always_comb begin
        next_ctr = update_ctr_i;
        if (inc_ctr_i) begin
            if (update_ctr_i != 2'b11) begin
                next_ctr = update_ctr_i + 2'd1;
            end
        end else if (update_ctr_i != 2'b00) begin
            next_ctr = update_ctr_i - 2'd1;
        end
    end

    pht_bram #(
        .DEPTH  (`BPU_BASE_DEPTH),
        .entry_t(bpu_pkg::base_ctr_t)
    ) u_table (
        .clk      (clk),
        .re_addr_i(query_index),
        .rd_data_o(ctr_o),
        .we_i     (update_valid_i),
        .wr_addr_i(update_index_i),
        .wr_data_i(next_ctr)
    );

endmodule

`default_nettype wire

//--- verilog/bpu_config.svh
// Branch predictor sizing
`ifndef BPU_CONFIG_SVH
`define BPU_CONFIG_SVH

// Fetch address width
`define BPU_ADDR_WIDTH 32

// Table depths
`define BPU_BASE_DEPTH 256
`define BPU_TAGGED_DEPTH 128

// Tagged entry fields
`define BPU_TAG_WIDTH 8
`define BPU_CTR_WIDTH 3
`define BPU_USEFUL_WIDTH 2

// History lengths, bank 0 short and bank 1 long
`define BPU_HIST_SHORT 4
`define BPU_HIST_LONG 12

// Global history register
`define BPU_GHR_WIDTH 16

`endif

//--- verilog/bpu_pkg.sv
// Predictor shared types
`default_nettype none

`include "bpu_config.svh"

package bpu_pkg;

    localparam int BASE_IDX_WIDTH = $clog2(`BPU_BASE_DEPTH);
    localparam int TAGGED_IDX_WIDTH = $clog2(`BPU_TAGGED_DEPTH);

    // One tagged bank entry
    typedef struct packed {
        logic [`BPU_CTR_WIDTH-1:0]    ctr;
        logic [`BPU_TAG_WIDTH-1:0]    tag;
        logic [`BPU_USEFUL_WIDTH-1:0] useful;
    } tagged_entry_t;

    // Bimodal counter, top bit gives the direction
    typedef logic [1:0] base_ctr_t;

    // Code 2'd3 is never produced
    typedef enum logic [1:0] {
        PROV_BASE  = 2'd0,
        PROV_BANK0 = 2'd1,
        PROV_BANK1 = 2'd2
    } provider_e;

    // What one bank saw for a query
    typedef struct packed {
        logic [TAGGED_IDX_WIDTH-1:0]  index;
        logic [`BPU_TAG_WIDTH-1:0]    tag;
        logic [`BPU_CTR_WIDTH-1:0]    ctr;
        logic [`BPU_USEFUL_WIDTH-1:0] useful;
        logic                         hit;
    } bank_meta_t;

    // Returned with a prediction, echoed back on resolve
    typedef struct packed {
        logic [BASE_IDX_WIDTH-1:0] base_index;
        base_ctr_t                 base_ctr;
        bank_meta_t [1:0]          bank;
        provider_e                 provider;
        logic                      alt_taken;
        logic                      taken;
    } pred_meta_t;

endpackage

`default_nettype wire

//--- verilog/csr_hash.sv
// Folded history register
`timescale 1ns/100ps
`default_nettype none

module csr_hash #(
    parameter int INPUT_LENGTH  = 4,
    parameter int OUTPUT_LENGTH = 7
) (
    input  wire logic                     clk,
    input  wire logic                     rst_i,
    input  wire logic                     data_update_i,
    // Bit 0 is the newest outcome, bit INPUT_LENGTH leaves the window
    input  wire logic [INPUT_LENGTH:0]    data_i,
    output logic      [OUTPUT_LENGTH-1:0] hash_o
);

    // Where the evicted bit lands after the rotate
    localparam int EVICT_POS = INPUT_LENGTH % OUTPUT_LENGTH;

    logic [OUTPUT_LENGTH-1:0] csr_q;
    logic [OUTPUT_LENGTH-1:0] csr_next;

    always_comb begin
        csr_next = {csr_q[OUTPUT_LENGTH-2:0], csr_q[OUTPUT_LENGTH-1]};
        csr_next[0] = csr_next[0] ^ data_i[0];
        csr_next[EVICT_POS] = csr_next[EVICT_POS] ^ data_i[INPUT_LENGTH];
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            csr_q <= '0;
        end else if (data_update_i) begin
            csr_q <= csr_next;
        end
    end

    assign hash_o = csr_q;

endmodule

`default_nettype wire

//--- verilog/pht_bram.sv
// Simple dual-port table RAM
`timescale 1ns/100ps
`default_nettype none

module pht_bram #(
    parameter int  DEPTH   = 128,
    parameter type entry_t = logic [7:0]
) (
    input  wire logic                     clk,
    // Port A, read only
    input  wire logic [$clog2(DEPTH)-1:0] re_addr_i,
    output entry_t                        rd_data_o,
    // Port B, write only
    input  wire logic                     we_i,
    input  wire logic [$clog2(DEPTH)-1:0] wr_addr_i,
    input  wire entry_t                   wr_data_i
);

    entry_t mem [DEPTH];

    // Tables start cleared
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    always @(posedge clk) begin
        if (we_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // Same-address collision returns the old entry
    always_ff @(posedge clk) begin
        rd_data_o <= mem[re_addr_i];
    end

endmodule

`default_nettype wire

//--- verilog/tage_predictor.sv
// TAGE direction predictor top
`timescale 1ns/100ps
`default_nettype none

`include "bpu_config.svh"

module tage_predictor (
    input  wire logic                        clk,
    input  wire logic                        rst_i,
    // Prediction
    input  wire logic                        pred_req_i,
    input  wire logic [`BPU_ADDR_WIDTH-1:0]  pc_i,
    output logic                             pred_valid_o,
    output logic                             pred_taken_o,
    output bpu_pkg::pred_meta_t              pred_meta_o,
    // Resolve
    input  wire logic                        resolve_valid_i,
    input  wire logic [`BPU_ADDR_WIDTH-1:0]  resolve_pc_i,
    input  wire logic                        resolve_taken_i,
    input  wire bpu_pkg::pred_meta_t         resolve_meta_i
);

    // Per-bank update controls
    typedef struct packed {
        logic valid;
        logic upd_ctr;
        logic inc_ctr;
        logic upd_useful;
        logic inc_useful;
        logic realloc;
    } bank_upd_t;

    logic [`BPU_GHR_WIDTH-1:0]          ghr_q;
    logic [`BPU_GHR_WIDTH-1:0]          ghr_next;
    logic [bpu_pkg::BASE_IDX_WIDTH-1:0] base_index;
    bpu_pkg::base_ctr_t                 base_ctr;
    bpu_pkg::bank_meta_t [1:0]          bank_meta;
    logic [1:0]                         bank_taken;
    bank_upd_t [1:0]                    upd;
    logic                               mispredict;
    logic                               prov_alt_differ;
    logic [1:0]                         prov_is_bank;
    logic [1:0]                         alloc_cand;
    logic [1:0]                         alloc_free;
    logic [1:0]                         alloc_sel;

    ////////////////////////////////////////
    // History and prediction
    ////////////////////////////////////////

    assign ghr_next = {ghr_q[`BPU_GHR_WIDTH-2:0], resolve_taken_i};

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ghr_q        <= '0;
            pred_valid_o <= 1'b0;
        end else begin
            pred_valid_o <= pred_req_i;
            if (resolve_valid_i) begin
                ghr_q <= ghr_next;
            end
        end
    end

    // Longest hitting bank provides, next one down is the alternate
    always_comb begin
        pred_meta_o.base_index = base_index;
        pred_meta_o.base_ctr   = base_ctr;
        pred_meta_o.bank       = bank_meta;
        if (bank_meta[1].hit) begin
            pred_meta_o.provider  = bpu_pkg::PROV_BANK1;
            pred_meta_o.taken     = bank_taken[1];
            pred_meta_o.alt_taken = bank_meta[0].hit ? bank_taken[0] : base_ctr[1];
        end else if (bank_meta[0].hit) begin
            pred_meta_o.provider  = bpu_pkg::PROV_BANK0;
            pred_meta_o.taken     = bank_taken[0];
            pred_meta_o.alt_taken = base_ctr[1];
        end else begin
            pred_meta_o.provider  = bpu_pkg::PROV_BASE;
            pred_meta_o.taken     = base_ctr[1];
            pred_meta_o.alt_taken = base_ctr[1];
        end
    end

    assign pred_taken_o = pred_meta_o.taken;

    ////////////////////////////////////////
    // Update policy
    ////////////////////////////////////////

    assign mispredict      = resolve_meta_i.taken != resolve_taken_i;
    assign prov_alt_differ = resolve_meta_i.taken != resolve_meta_i.alt_taken;
    assign prov_is_bank[0] = resolve_meta_i.provider == bpu_pkg::PROV_BANK0;
    assign prov_is_bank[1] = resolve_meta_i.provider == bpu_pkg::PROV_BANK1;

    // Banks with longer history than the provider
    assign alloc_cand[0] = resolve_meta_i.provider == bpu_pkg::PROV_BASE;
    assign alloc_cand[1] = !prov_is_bank[1];
    assign alloc_free[0] = alloc_cand[0] && (resolve_meta_i.bank[0].useful == '0);
    assign alloc_free[1] = alloc_cand[1] && (resolve_meta_i.bank[1].useful == '0);
    // Shortest free bank wins
    assign alloc_sel = {alloc_free[1] && !alloc_free[0], alloc_free[0]};

    always_comb begin
        upd = '0;
        for (int k = 0; k < 2; k++) begin
            upd[k].inc_ctr = resolve_taken_i;
            if (prov_is_bank[k]) begin
                upd[k].upd_ctr    = 1'b1;
                upd[k].upd_useful = prov_alt_differ;
                upd[k].inc_useful = !mispredict;
            end
            if (mispredict && alloc_sel[k]) begin
                upd[k].realloc = 1'b1;
            end else if (mispredict && alloc_cand[k] && (alloc_free == 2'b00)) begin
                // Nothing free, age the candidates instead
                upd[k].upd_useful = 1'b1;
                upd[k].inc_useful = 1'b0;
            end
            upd[k].valid = resolve_valid_i &&
                           (upd[k].upd_ctr || upd[k].upd_useful || upd[k].realloc);
        end
    end

    ////////////////////////////////////////
    // Predictor tables
    ////////////////////////////////////////

    base_predictor u_base (
        .clk           (clk),
        .rst_i         (rst_i),
        .pc_i          (pc_i),
        .base_index_o  (base_index),
        .ctr_o         (base_ctr),
        .update_valid_i(resolve_valid_i && (resolve_meta_i.provider == bpu_pkg::PROV_BASE)),
        .update_index_i(resolve_pc_i[2 +: bpu_pkg::BASE_IDX_WIDTH]),
        .update_ctr_i  (resolve_meta_i.base_ctr),
        .inc_ctr_i     (resolve_taken_i)
    );

    for (genvar k = 0; k < 2; k++) begin : g_bank
        localparam int HIST = (k == 0) ? `BPU_HIST_SHORT : `BPU_HIST_LONG;

        tagged_predictor #(.HIST_LENGTH(HIST)) u_bank (
            .clk                    (clk),
            .rst_i                  (rst_i),
            .global_history_update_i(resolve_valid_i),
            .global_history_i       (ghr_next[HIST:0]),
            .pc_i                   (pc_i),
            .meta_o                 (bank_meta[k]),
            .taken_o                (bank_taken[k]),
            .update_valid_i         (upd[k].valid),
            .update_ctr_i           (upd[k].upd_ctr),
            .inc_ctr_i              (upd[k].inc_ctr),
            .update_useful_i        (upd[k].upd_useful),
            .inc_useful_i           (upd[k].inc_useful),
            .realloc_entry_i        (upd[k].realloc),
            .update_index_i         (resolve_meta_i.bank[k].index),
            .update_tag_i           (resolve_meta_i.bank[k].tag),
            .update_ctr_bits_i      (resolve_meta_i.bank[k].ctr),
            .update_useful_bits_i   (resolve_meta_i.bank[k].useful)
        );
    end

endmodule

`default_nettype wire

//--- verilog/tagged_predictor.sv
// Tagged history bank
`timescale 1ns/100ps
`default_nettype none

`include "bpu_config.svh"

module tagged_predictor #(
    parameter int HIST_LENGTH = `BPU_HIST_SHORT
) (
    input  wire logic                                  clk,
    input  wire logic                                  rst_i,
    // History, bit 0 newest
    input  wire logic                                  global_history_update_i,
    input  wire logic [HIST_LENGTH:0]                  global_history_i,
    // Query
    input  wire logic [`BPU_ADDR_WIDTH-1:0]            pc_i,
    output bpu_pkg::bank_meta_t                        meta_o,
    output logic                                       taken_o,
    // Update
    input  wire logic                                  update_valid_i,
    input  wire logic                                  update_ctr_i,
    input  wire logic                                  inc_ctr_i,
    input  wire logic                                  update_useful_i,
    input  wire logic                                  inc_useful_i,
    input  wire logic                                  realloc_entry_i,
    input  wire logic [bpu_pkg::TAGGED_IDX_WIDTH-1:0]  update_index_i,
    input  wire logic [`BPU_TAG_WIDTH-1:0]             update_tag_i,
    input  wire logic [`BPU_CTR_WIDTH-1:0]             update_ctr_bits_i,
    input  wire logic [`BPU_USEFUL_WIDTH-1:0]          update_useful_bits_i
);

    localparam int IDX_W = bpu_pkg::TAGGED_IDX_WIDTH;
    localparam int TAG_W = `BPU_TAG_WIDTH;
    localparam int CTR_W = `BPU_CTR_WIDTH;

    localparam logic [CTR_W-1:0] WEAK_TAKEN     = {1'b1, {(CTR_W - 1){1'b0}}};
    localparam logic [CTR_W-1:0] WEAK_NOT_TAKEN = {1'b0, {(CTR_W - 1){1'b1}}};

    logic [IDX_W-1:0]       hist_fold;
    logic [TAG_W-1:0]       tag_fold1;
    logic [TAG_W-2:0]       tag_fold2;
    logic [IDX_W-1:0]       query_index;
    logic [IDX_W-1:0]       query_index_q;
    logic [TAG_W-1:0]       query_tag;
    logic [TAG_W-1:0]       query_tag_q;
    bpu_pkg::tagged_entry_t rd_entry;
    bpu_pkg::tagged_entry_t wr_entry;

    ////////////////////////////////////////
    // Query
    ////////////////////////////////////////

    assign query_index = pc_i[0 +: IDX_W] ^ pc_i[IDX_W +: IDX_W] ^ hist_fold;
    // Second fold shifted so the two tag hashes differ
    assign query_tag = pc_i[2 +: TAG_W] ^ tag_fold1 ^ {tag_fold2, 1'b0};

    always_ff @(posedge clk) begin
        query_index_q <= query_index;
        query_tag_q   <= query_tag;
    end

    always_comb begin
        meta_o.index  = query_index_q;
        meta_o.tag    = query_tag_q;
        meta_o.ctr    = rd_entry.ctr;
        meta_o.useful = rd_entry.useful;
        meta_o.hit    = (query_tag_q == rd_entry.tag);
    end

    assign taken_o = rd_entry.ctr[CTR_W-1];

    ////////////////////////////////////////
    // Update
    ////////////////////////////////////////

    always_comb begin
        wr_entry.tag    = update_tag_i;
        wr_entry.ctr    = update_ctr_bits_i;
        wr_entry.useful = update_useful_bits_i;
        if (update_ctr_i) begin
            if (inc_ctr_i) begin
                if (update_ctr_bits_i != '1) begin
                    wr_entry.ctr = update_ctr_bits_i + 1'b1;
                end
            end else if (update_ctr_bits_i != '0) begin
                wr_entry.ctr = update_ctr_bits_i - 1'b1;
            end
        end
        if (update_useful_i) begin
            if (inc_useful_i) begin
                if (update_useful_bits_i != '1) begin
                    wr_entry.useful = update_useful_bits_i + 1'b1;
                end
            end else if (update_useful_bits_i != '0) begin
                wr_entry.useful = update_useful_bits_i - 1'b1;
            end
        end
        // New owner starts weak in the resolved direction
        if (realloc_entry_i) begin
            wr_entry.ctr    = inc_ctr_i ? WEAK_TAKEN : WEAK_NOT_TAKEN;
            wr_entry.useful = '0;
        end
    end

    ////////////////////////////////////////
    // History folds and table
    ////////////////////////////////////////

    csr_hash #(.INPUT_LENGTH(HIST_LENGTH), .OUTPUT_LENGTH(IDX_W)) u_index_hash (
        .clk(clk), .rst_i(rst_i), .data_update_i(global_history_update_i),
        .data_i(global_history_i), .hash_o(hist_fold)
    );

    csr_hash #(.INPUT_LENGTH(HIST_LENGTH), .OUTPUT_LENGTH(TAG_W)) u_tag_hash1 (
        .clk(clk), .rst_i(rst_i), .data_update_i(global_history_update_i),
        .data_i(global_history_i), .hash_o(tag_fold1)
    );

    csr_hash #(.INPUT_LENGTH(HIST_LENGTH), .OUTPUT_LENGTH(TAG_W - 1)) u_tag_hash2 (
        .clk(clk), .rst_i(rst_i), .data_update_i(global_history_update_i),
        .data_i(global_history_i), .hash_o(tag_fold2)
    );

    pht_bram #(
        .DEPTH  (`BPU_TAGGED_DEPTH),
        .entry_t(bpu_pkg::tagged_entry_t)
    ) u_table (
        .clk      (clk),
        .re_addr_i(query_index),
        .rd_data_o(rd_entry),
        .we_i     (update_valid_i),
        .wr_addr_i(update_index_i),
        .wr_data_i(wr_entry)
    );

endmodule

`default_nettype wire
